// File: include/rp_cfg.svh
//////////////////////////////////////////////////////////////////////
// Widths, address map split and ID word of the analog front end
//////////////////////////////////////////////////////////////////////

`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// Analog data widths
`define RP_ADC_RAW_W 16          // Raw ADC word, two low bits reserved
`define RP_SMP_W     14          // Converted sample and DAC code

// System bus
`define RP_DATA_W    32          // Bus data
`define RP_ADDR_W    14          // Host address
`define RP_OFS_W     12          // Offset inside one region

// Upper RP_ADDR_W-RP_OFS_W bits pick the region

// Peripherals
`define RP_CNT_N     4           // Edge counter inputs
`define RP_LED_W     8           // LED register

// Identification word at housekeeping offset 0x000
`define RP_HK_ID     32'h5250_0A01

`endif

// File: src/rp_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types: analog samples, host and slave bus structs, enums
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

package rp_pkg;

  // Analog stream types
  typedef logic signed [`RP_SMP_W-1:0]     smp_t;       // Two's complement sample
  typedef logic        [`RP_ADC_RAW_W-1:0] adc_raw_t;   // Raw ADC pins
  typedef logic        [`RP_SMP_W-1:0]     dac_code_t;  // Negative slope DAC code

  //////////////////////////////////////////////////////////////////////
  // Host port, four phase req/ack
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  req;     // Held until ack seen
    logic                  wen;     // Write when set
    logic [`RP_ADDR_W-1:0] addr;
    logic [`RP_DATA_W-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic                  ack;     // Held until req falls
    logic                  err;
    logic [`RP_DATA_W-1:0] rdata;
  } host_rsp_t;

  // Internal slave port, single cycle strobe
  typedef struct packed {
    logic                  stb;
    logic                  wen;
    logic [`RP_OFS_W-1:0]  ofs;     // Offset inside region
    logic [`RP_DATA_W-1:0] wdata;
  } sys_req_t;

  typedef struct packed {
    logic                  ack;     // One cycle after stb
    logic                  err;     // Unknown offset or read only
    logic [`RP_DATA_W-1:0] rdata;
  } sys_rsp_t;

  // Region select from upper address bits
  typedef enum logic [`RP_ADDR_W-`RP_OFS_W-1:0] {
    REG_HK  = 2'd0,
    REG_ADC = 2'd1,
    REG_DAC = 2'd2,
    REG_CNT = 2'd3
  } sys_region_e;

  // Decoder FSM
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_WAIT,
    BUS_DONE
  } bus_state_e;

endpackage

// File: src/rp_sys_decoder.sv
//////////////////////////////////////////////////////////////////////
// Host handshake FSM, region decode and slave response select
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_sys_decoder import rp_pkg::*;
(
  input  logic           adc_clk,
  input  logic           rst_n_i,     // Synchronous, active low
  // Host side
  input  host_req_t      host_req_i,
  output host_rsp_t      host_rsp_o,
  // One port per region
  output sys_req_t [3:0] sys_req_o,
  input  sys_rsp_t [3:0] sys_rsp_i
);

bus_state_e            state_q;
sys_region_e           region_q;   // Latched target
logic                  stb_q;
logic                  wen_q;
logic [`RP_OFS_W-1:0]  ofs_q;
logic [`RP_DATA_W-1:0] wdata_q;
host_rsp_t             rsp_q;      // Held result for host
sys_rsp_t              sel_rsp;

// Response of the addressed slave
assign sel_rsp = sys_rsp_i[region_q];

//////////////////////////////////////////////////////////////////////
// Handshake FSM
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    state_q <= BUS_IDLE;
    stb_q   <= 1'b0;
    rsp_q   <= '0;
  end
  else
  begin
    case (state_q)
      BUS_IDLE:
      begin
        if (host_req_i.req)
        begin
          stb_q   <= 1'b1;          // Single strobe cycle
          state_q <= BUS_WAIT;
        end
      end
      BUS_WAIT:
      begin
        stb_q <= 1'b0;
        if (sel_rsp.ack)
        begin
          rsp_q.ack   <= 1'b1;
          rsp_q.err   <= sel_rsp.err;
          rsp_q.rdata <= sel_rsp.rdata;
          state_q     <= BUS_DONE;
        end
      end
      BUS_DONE:
      begin
        // Hold result until host lets go
        if (!host_req_i.req)
        begin
          rsp_q   <= '0;
          state_q <= BUS_IDLE;
        end
      end
      default: state_q <= BUS_IDLE;
    endcase
  end
end

// Request fields, captured on acceptance
always_ff @(posedge adc_clk)
begin
  if (state_q == BUS_IDLE && host_req_i.req)
  begin
    region_q <= sys_region_e'(host_req_i.addr[`RP_ADDR_W-1:`RP_OFS_W]);
    wen_q    <= host_req_i.wen;
    ofs_q    <= host_req_i.addr[`RP_OFS_W-1:0];
    wdata_q  <= host_req_i.wdata;
  end
end

// Fan out, strobe only to the selected region
always_comb
begin
  for (int r = 0; r < 4; r++)
  begin
    sys_req_o[r].stb   = stb_q && (region_q == sys_region_e'(r));
    sys_req_o[r].wen   = wen_q;
    sys_req_o[r].ofs   = ofs_q;
    sys_req_o[r].wdata = wdata_q;
  end
end

assign host_rsp_o = rsp_q;

endmodule

// File: src/rp_hk_regs.sv
//////////////////////////////////////////////////////////////////////
// Housekeeping registers: ID word, digital loop switch, LEDs
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_hk_regs import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  sys_req_t             sys_req_i,
  output sys_rsp_t             sys_rsp_o,
  output logic                 digital_loop_o,  // DAC to ADC loop
  output logic [`RP_LED_W-1:0] led_o
);

logic                  loop_q;
logic [`RP_LED_W-1:0]  led_q;
sys_rsp_t              rsp_q;
logic                  rd_err;
logic [`RP_DATA_W-1:0] rd_dat;

// Offset decode
always_comb
begin
  rd_err = 1'b0;
  rd_dat = '0;
  case (sys_req_i.ofs)
    'h000:
    begin
      rd_dat = `RP_HK_ID;
      rd_err = sys_req_i.wen;              // ID is read only
    end
    'h004:   rd_dat = `RP_DATA_W'(loop_q);
    'h008:   rd_dat = `RP_DATA_W'(led_q);
    default: rd_err = 1'b1;                // Not mapped
  endcase
end

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    loop_q <= 1'b0;
    led_q  <= '0;
    rsp_q  <= '0;
  end
  else
  begin
    // Answer one cycle after strobe
    rsp_q.ack   <= sys_req_i.stb;
    rsp_q.err   <= sys_req_i.stb && rd_err;
    rsp_q.rdata <= (sys_req_i.stb && !rd_err) ? rd_dat : '0;
    if (sys_req_i.stb && sys_req_i.wen)
    begin
      case (sys_req_i.ofs)
        'h004:   loop_q <= sys_req_i.wdata[0];
        'h008:   led_q  <= sys_req_i.wdata[`RP_LED_W-1:0];
        default: ;                         // Flagged above
      endcase
    end
  end
end

assign sys_rsp_o      = rsp_q;
assign digital_loop_o = loop_q;
assign led_o          = led_q;

endmodule

// File: src/rp_adc_in.sv
//////////////////////////////////////////////////////////////////////
// ADC capture, negative slope to two's complement, loopback, readback
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_adc_in import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_n_i,
  input  adc_raw_t adc_dat_a_i,
  input  adc_raw_t adc_dat_b_i,
  input  logic     digital_loop_i,   // Take DAC values instead
  input  smp_t     dac_a_i,          // Saturated DAC value A
  input  smp_t     dac_b_i,
  input  sys_req_t sys_req_i,
  output sys_rsp_t sys_rsp_o
);

adc_raw_t [1:0]             adc_in;
smp_t     [1:0]             dac_in;
logic     [1:0][`RP_SMP_W-1:0] raw_q;  // Input register
smp_t     [1:0]             conv;
smp_t     [1:0]             smp_q;     // Sample register
smp_t                       rd_smp;
logic                       rd_err;
sys_rsp_t                   rsp_q;

assign adc_in = {adc_dat_b_i, adc_dat_a_i};
assign dac_in = {dac_b_i, dac_a_i};

//////////////////////////////////////////////////////////////////////
// Sample pipeline
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  for (int ch = 0; ch < 2; ch++)
  begin
    raw_q[ch] <= adc_in[ch][`RP_ADC_RAW_W-1 -: `RP_SMP_W];  // Drop 2 LSBs
    smp_q[ch] <= digital_loop_i ? dac_in[ch] : conv[ch];
  end
end

// Keep MSB, invert the rest
always_comb
begin
  for (int ch = 0; ch < 2; ch++)
    conv[ch] = {raw_q[ch][`RP_SMP_W-1], ~raw_q[ch][`RP_SMP_W-2:0]};
end

// Two read only words at 0x000 and 0x004
assign rd_err = sys_req_i.wen || !(sys_req_i.ofs == 'h000 || sys_req_i.ofs == 'h004);
assign rd_smp = smp_q[sys_req_i.ofs[2]];

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
    rsp_q <= '0;
  else
  begin
    rsp_q.ack   <= sys_req_i.stb;
    rsp_q.err   <= sys_req_i.stb && rd_err;
    rsp_q.rdata <= (sys_req_i.stb && !rd_err) ?
                   {{(`RP_DATA_W-`RP_SMP_W){rd_smp[`RP_SMP_W-1]}}, rd_smp} : '0;
  end
end

assign sys_rsp_o = rsp_q;

endmodule

// File: src/rp_dac_out.sv
//////////////////////////////////////////////////////////////////////
// DAC level and offset registers, saturating sum, output codes
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_dac_out import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  sys_req_t  sys_req_i,
  output sys_rsp_t  sys_rsp_o,
  output smp_t      dac_a_o,       // Saturated sum, to loopback
  output smp_t      dac_b_o,
  output dac_code_t dac_dat_a_o,   // Registered DAC codes
  output dac_code_t dac_dat_b_o
);

// Register file, index {ch, is_offset}
smp_t [3:0]                 regs_q;
logic signed [`RP_SMP_W:0]  sum [2];   // One guard bit
smp_t [1:0]                 sat;
dac_code_t [1:0]            code_q;
logic                       rd_err;
smp_t                       rd_reg;
sys_rsp_t                   rsp_q;

//////////////////////////////////////////////////////////////////////
// Sum and saturation
//////////////////////////////////////////////////////////////////////

always_comb
begin
  for (int ch = 0; ch < 2; ch++)
  begin
    sum[ch] = {regs_q[2*ch][`RP_SMP_W-1], regs_q[2*ch]}
            + {regs_q[2*ch+1][`RP_SMP_W-1], regs_q[2*ch+1]};
    // Top two bits differ on overflow
    if (sum[ch][`RP_SMP_W] ^ sum[ch][`RP_SMP_W-1])
      sat[ch] = {sum[ch][`RP_SMP_W], {(`RP_SMP_W-1){~sum[ch][`RP_SMP_W]}}};
    else
      sat[ch] = sum[ch][`RP_SMP_W-1:0];
  end
end

// Four words 0x000..0x00C
assign rd_err = (sys_req_i.ofs[`RP_OFS_W-1:4] != '0) || (sys_req_i.ofs[1:0] != 2'b00);
assign rd_reg = regs_q[sys_req_i.ofs[3:2]];

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    regs_q <= '0;
    code_q <= {2{1'b0, {(`RP_SMP_W-1){1'b1}}}};   // Code for zero
    rsp_q  <= '0;
  end
  else
  begin
    // Back to unsigned negative slope
    for (int ch = 0; ch < 2; ch++)
      code_q[ch] <= {sat[ch][`RP_SMP_W-1], ~sat[ch][`RP_SMP_W-2:0]};
    rsp_q.ack   <= sys_req_i.stb;
    rsp_q.err   <= sys_req_i.stb && rd_err;
    rsp_q.rdata <= (sys_req_i.stb && !rd_err) ?
                   {{(`RP_DATA_W-`RP_SMP_W){rd_reg[`RP_SMP_W-1]}}, rd_reg} : '0;
    if (sys_req_i.stb && sys_req_i.wen && !rd_err)
      regs_q[sys_req_i.ofs[3:2]] <= sys_req_i.wdata[`RP_SMP_W-1:0];
  end
end

assign sys_rsp_o   = rsp_q;
assign dac_a_o     = sat[0];
assign dac_b_o     = sat[1];
assign dac_dat_a_o = code_q[0];
assign dac_dat_b_o = code_q[1];

endmodule

// File: src/rp_edge_counter.sv
//////////////////////////////////////////////////////////////////////
// Rising edge counters with input synchronisers, bus read and clear
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_edge_counter import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [`RP_CNT_N-1:0] cnt_in_i,   // Asynchronous inputs
  input  sys_req_t             sys_req_i,
  output sys_rsp_t             sys_rsp_o
);

localparam int IDX_W = $clog2(`RP_CNT_N);

logic [`RP_CNT_N-1:0]  sync1_q, sync2_q;  // Two flop synchroniser
logic [`RP_CNT_N-1:0]  edge_q;            // Previous synced level
logic [`RP_CNT_N-1:0]  rise;
logic [`RP_DATA_W-1:0] cnt_q [`RP_CNT_N];
logic [IDX_W-1:0]      idx;
logic                  rd_err;
sys_rsp_t              rsp_q;

assign rise = sync2_q & ~edge_q;

// Word per counter from 0x000
assign idx    = sys_req_i.ofs[IDX_W+1:2];
assign rd_err = ((sys_req_i.ofs >> 2) >= `RP_CNT_N) || (sys_req_i.ofs[1:0] != 2'b00);

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    sync1_q <= '0;
    sync2_q <= '0;
    edge_q  <= '0;
    rsp_q   <= '0;
    for (int i = 0; i < `RP_CNT_N; i++)
      cnt_q[i] <= '0;
  end
  else
  begin
    sync1_q <= cnt_in_i;
    sync2_q <= sync1_q;
    edge_q  <= sync2_q;
    for (int i = 0; i < `RP_CNT_N; i++)
    begin
      // Clear wins over a coincident edge
      if (sys_req_i.stb && sys_req_i.wen && !rd_err && idx == IDX_W'(i))
        cnt_q[i] <= '0;
      else if (rise[i])
        cnt_q[i] <= cnt_q[i] + 1'b1;
    end
    rsp_q.ack   <= sys_req_i.stb;
    rsp_q.err   <= sys_req_i.stb && rd_err;
    rsp_q.rdata <= (sys_req_i.stb && !rd_err) ? cnt_q[idx] : '0;
  end
end

assign sys_rsp_o = rsp_q;

endmodule

// File: src/rp_analog_top.sv
//////////////////////////////////////////////////////////////////////
// Analog front end top: bus decoder with HK, ADC, DAC, counter slaves
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_analog_top import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // Host bus
  input  host_req_t            host_req_i,
  output host_rsp_t            host_rsp_o,
  // ADC pins
  input  adc_raw_t             adc_dat_a_i,
  input  adc_raw_t             adc_dat_b_i,
  // DAC pins, one port per channel
  output dac_code_t            dac_dat_a_o,
  output dac_code_t            dac_dat_b_o,
  // Counter inputs and LEDs
  input  logic [`RP_CNT_N-1:0] cnt_in_i,
  output logic [`RP_LED_W-1:0] led_o
);

sys_req_t [3:0] sys_req;
sys_rsp_t [3:0] sys_rsp;
logic           digital_loop;   // HK to ADC path
smp_t           dac_a, dac_b;   // Saturated DAC values

//////////////////////////////////////////////////////////////////////
// Bus decoder
//////////////////////////////////////////////////////////////////////

rp_sys_decoder i_dec (
  .adc_clk    (adc_clk   ),
  .rst_n_i    (rst_n_i   ),
  .host_req_i (host_req_i),
  .host_rsp_o (host_rsp_o),
  .sys_req_o  (sys_req   ),
  .sys_rsp_i  (sys_rsp   )
);

// Housekeeping
rp_hk_regs i_hk (
  .adc_clk        (adc_clk         ),
  .rst_n_i        (rst_n_i         ),
  .sys_req_i      (sys_req[REG_HK] ),
  .sys_rsp_o      (sys_rsp[REG_HK] ),
  .digital_loop_o (digital_loop    ),
  .led_o          (led_o           )
);

// ADC input path
rp_adc_in i_adc (
  .adc_clk        (adc_clk         ),
  .rst_n_i        (rst_n_i         ),
  .adc_dat_a_i    (adc_dat_a_i     ),
  .adc_dat_b_i    (adc_dat_b_i     ),
  .digital_loop_i (digital_loop    ),
  .dac_a_i        (dac_a           ),
  .dac_b_i        (dac_b           ),
  .sys_req_i      (sys_req[REG_ADC]),
  .sys_rsp_o      (sys_rsp[REG_ADC])
);

// DAC output path
rp_dac_out i_dac (
  .adc_clk     (adc_clk         ),
  .rst_n_i     (rst_n_i         ),
  .sys_req_i   (sys_req[REG_DAC]),
  .sys_rsp_o   (sys_rsp[REG_DAC]),
  .dac_a_o     (dac_a           ),
  .dac_b_o     (dac_b           ),
  .dac_dat_a_o (dac_dat_a_o     ),
  .dac_dat_b_o (dac_dat_b_o     )
);

// Edge counters
rp_edge_counter i_cnt (
  .adc_clk   (adc_clk         ),
  .rst_n_i   (rst_n_i         ),
  .cnt_in_i  (cnt_in_i        ),
  .sys_req_i (sys_req[REG_CNT]),
  .sys_rsp_o (sys_rsp[REG_CNT])
);

endmodule

// File: test/rp_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock, period 40, and synchronous reset pulse
//////////////////////////////////////////////////////////////////////

module rp_clk_gen
(
  output logic adc_clk_o,
  output logic rst_n_o     // Low for the first 5 cycles
);

initial
begin
  adc_clk_o = 1'b0;
  forever #20 adc_clk_o = ~adc_clk_o;
end

initial
begin
  rst_n_o = 1'b0;
  repeat (5) @(posedge adc_clk_o);
  @(negedge adc_clk_o);   // Release away from the active edge
  rst_n_o = 1'b1;
end

endmodule

// File: test/rp_analog_sva.sv
//////////////////////////////////////////////////////////////////////
// Four phase host handshake checks, bound into the bus decoder
//////////////////////////////////////////////////////////////////////

module rp_analog_sva
  import rp_pkg::*;
(
  input logic      adc_clk,
  input logic      rst_n_i,
  input host_req_t host_req_i,
  input host_rsp_t host_rsp_i   // Decoder host response
);

// Ack only answers a pending request
ack_needs_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  $rose(host_rsp_i.ack) |-> $past(host_req_i.req))
  else $error("host ack rose without a request");

// Result held while the host still requests
ack_held: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  host_rsp_i.ack && host_req_i.req |=> host_rsp_i.ack)
  else $error("host ack dropped while req was high");

// Release one cycle after req falls
ack_release: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  host_rsp_i.ack && !host_req_i.req |=> !host_rsp_i.ack)
  else $error("host ack not released after req fell");

endmodule

bind rp_sys_decoder rp_analog_sva i_sva (
  .adc_clk    (adc_clk   ),
  .rst_n_i    (rst_n_i   ),
  .host_req_i (host_req_i),
  .host_rsp_i (host_rsp_o)
);

// File: test/rp_analog_tb.sv
//////////////////////////////////////////////////////////////////////
// Directed tests of the analog front end: bus, ADC, DAC, loop, counters
//////////////////////////////////////////////////////////////////////

`include "rp_cfg.svh"

module rp_analog_tb
  import rp_pkg::*;
();

// About 120 bus accesses of ~8 cycles plus counter pulses, well below
localparam int TIMEOUT_CYC = 20000;
localparam int SMP_MAX     = (1 << (`RP_SMP_W - 1)) - 1;   // +8191
localparam int SMP_MIN     = -(1 << (`RP_SMP_W - 1));      // -8192

logic                 adc_clk;
logic                 rst_n;
host_req_t            host_req;
host_rsp_t            host_rsp;
adc_raw_t             adc_dat_a, adc_dat_b;
dac_code_t            dac_dat_a, dac_dat_b;
logic [`RP_CNT_N-1:0] cnt_in;
logic [`RP_LED_W-1:0] led;

logic [31:0] lfsr_q;      // Fibonacci LFSR state
int          cycles;
int          err_cnt;
int          check_cnt;
int          test_cnt;
int          test_errs;   // Error count when the test began
string       test_name;

rp_clk_gen i_clk (
  .adc_clk_o (adc_clk),
  .rst_n_o   (rst_n  )
);

rp_analog_top dut (
  .adc_clk     (adc_clk  ),
  .rst_n_i     (rst_n    ),
  .host_req_i  (host_req ),
  .host_rsp_o  (host_rsp ),
  .adc_dat_a_i (adc_dat_a),
  .adc_dat_b_i (adc_dat_b),
  .dac_dat_a_o (dac_dat_a),
  .dac_dat_b_o (dac_dat_b),
  .cnt_in_i    (cnt_in   ),
  .led_o       (led      )
);

// Watchdog
always @(posedge adc_clk)
begin
  cycles <= cycles + 1;
  if (cycles >= TIMEOUT_CYC)
  begin
    $display("Timeout: tests still running after %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
  end
end

//////////////////////////////////////////////////////////////////////
// Random bits and reference models
//////////////////////////////////////////////////////////////////////

// One LFSR step per bit, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    v      = {v[30:0], fb};
  end
  return v;
endfunction

function automatic int rand_signed(input int n);
  int v;
  v = int'(rand_bits(n));
  if (v >= (1 << (n - 1)))
    v = v - (1 << n);        // Two's complement of n bits
  return v;
endfunction

// Top raw bit, then raw bits 14..2 inverted, sign extended
function automatic logic [`RP_DATA_W-1:0] adc_word(input adc_raw_t raw);
  logic [`RP_SMP_W-1:0] s;
  s = {raw[`RP_ADC_RAW_W-1], ~raw[`RP_ADC_RAW_W-2:2]};
  return {{(`RP_DATA_W-`RP_SMP_W){s[`RP_SMP_W-1]}}, s};
endfunction

function automatic int clamp_sum(input int level, input int offset);
  int s;
  s = level + offset;
  if (s > SMP_MAX)
    s = SMP_MAX;
  else if (s < SMP_MIN)
    s = SMP_MIN;
  return s;
endfunction

// Negative slope code: sign kept, lower bits inverted
function automatic dac_code_t code_for(input int value);
  logic [`RP_SMP_W-1:0] v;
  v = value[`RP_SMP_W-1:0];
  return {v[`RP_SMP_W-1], ~v[`RP_SMP_W-2:0]};
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks and bookkeeping
//////////////////////////////////////////////////////////////////////

task automatic check_data(input string what, input logic [`RP_DATA_W-1:0] exp,
                          input logic [`RP_DATA_W-1:0] act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_code(input string what, input dac_code_t exp, input dac_code_t act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_err(input string what, input logic exp, input logic act);
  check_cnt++;
  if (act !== exp)
  begin
    err_cnt++;
    $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
  end
endtask

task automatic start_test(input string name);
  test_name = name;
  test_errs = err_cnt;
endtask

task automatic finish_test();
  test_cnt++;
  $display("%-16s done, %0d errors", test_name, err_cnt - test_errs);
endtask

// Four phase cycle, inputs change on the falling edge
task automatic host_cycle(input logic wen, input logic [`RP_ADDR_W-1:0] addr,
                          input logic [`RP_DATA_W-1:0] wdata,
                          output logic [`RP_DATA_W-1:0] rdata, output logic err);
  @(negedge adc_clk);
  host_req.wen   = wen;
  host_req.addr  = addr;
  host_req.wdata = wdata;
  host_req.req   = 1'b1;
  @(negedge adc_clk);
  while (!host_rsp.ack)
    @(negedge adc_clk);
  rdata        = host_rsp.rdata;
  err          = host_rsp.err;
  host_req.req = 1'b0;
  @(negedge adc_clk);
  while (host_rsp.ack)     // Next request only after ack falls
    @(negedge adc_clk);
endtask

task automatic bus_write(input sys_region_e rgn, input int ofs,
                         input logic [`RP_DATA_W-1:0] wdata, output logic err);
  logic [`RP_DATA_W-1:0] rdata;
  host_cycle(1'b1, {rgn, `RP_OFS_W'(ofs)}, wdata, rdata, err);
endtask

task automatic bus_read(input sys_region_e rgn, input int ofs,
                        output logic [`RP_DATA_W-1:0] rdata, output logic err);
  host_cycle(1'b0, {rgn, `RP_OFS_W'(ofs)}, '0, rdata, err);
endtask

// Level and offset of both channels
task automatic write_dac(input int la, input int oa, input int lb, input int ob);
  logic err;
  bus_write(REG_DAC, 'h000, la, err);
  check_err("level a err", 1'b0, err);
  bus_write(REG_DAC, 'h004, oa, err);
  check_err("offset a err", 1'b0, err);
  bus_write(REG_DAC, 'h008, lb, err);
  check_err("level b err", 1'b0, err);
  bus_write(REG_DAC, 'h00C, ob, err);
  check_err("offset b err", 1'b0, err);
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic hk_and_errors();
  logic [`RP_DATA_W-1:0] rd;
  logic                  err;
  logic [`RP_LED_W-1:0]  led_val;
  int                    bad_ofs [4] = '{'h00C, 'h008, 'h010, 'h010};  // Per region
  start_test("hk_and_errors");
  check_data("led reset", '0, led);
  bus_read(REG_HK, 'h000, rd, err);
  check_data("id", `RP_HK_ID, rd);
  check_err("id err", 1'b0, err);
  bus_write(REG_HK, 'h000, '1, err);    // Read only
  check_err("id write", 1'b1, err);
  bus_write(REG_ADC, 'h000, '0, err);   // Read only
  check_err("adc write", 1'b1, err);
  for (int r = 0; r < 4; r++)
  begin
    bus_read(sys_region_e'(r), bad_ofs[r], rd, err);
    check_err("unmapped err", 1'b1, err);
    check_data("unmapped rdata", '0, rd);
  end
  for (int i = 0; i < 3; i++)
  begin
    led_val = rand_bits(`RP_LED_W);
    bus_write(REG_HK, 'h008, led_val, err);
    check_err("led err", 1'b0, err);
    check_data("led pins", led_val, led);
    bus_read(REG_HK, 'h008, rd, err);
    check_data("led readback", led_val, rd);
  end
  finish_test();
endtask

task automatic adc_conversion();
  logic [`RP_DATA_W-1:0] rd;
  logic                  err;
  adc_raw_t              raw_a, raw_b;
  start_test("adc_conversion");
  for (int i = 0; i < 8; i++)
  begin
    raw_a     = rand_bits(`RP_ADC_RAW_W);
    raw_b     = rand_bits(`RP_ADC_RAW_W);
    adc_dat_a = raw_a;
    adc_dat_b = raw_b;
    repeat (3) @(negedge adc_clk);       // Input and sample registers
    bus_read(REG_ADC, 'h000, rd, err);
    check_data("sample a", adc_word(raw_a), rd);
    bus_read(REG_ADC, 'h004, rd, err);
    check_data("sample b", adc_word(raw_b), rd);
    check_err("sample err", 1'b0, err);
  end
  finish_test();
endtask

task automatic dac_sum();
  int la, oa, lb, ob;
  start_test("dac_sum");
  check_code("reset a", code_for(0), dac_dat_a);
  check_code("reset b", code_for(0), dac_dat_b);
  for (int i = 0; i < 6; i++)
  begin
    la = rand_signed(12);               // Sum stays in range
    oa = rand_signed(12);
    lb = rand_signed(12);
    ob = rand_signed(12);
    write_dac(la, oa, lb, ob);
    @(negedge adc_clk);
    check_code("code a", code_for(la + oa), dac_dat_a);
    check_code("code b", code_for(lb + ob), dac_dat_b);
  end
  finish_test();
endtask

task automatic dac_saturation();
  int la, oa, lb, ob;
  start_test("dac_saturation");
  for (int i = 0; i < 4; i++)
  begin
    la = SMP_MAX - int'(rand_bits(12));  // A above +8191
    oa = 4096 + int'(rand_bits(12));
    lb = SMP_MIN + int'(rand_bits(12));  // B below -8192
    ob = -4096 - int'(rand_bits(12));
    write_dac(la, oa, lb, ob);
    @(negedge adc_clk);
    check_code("clamp high", code_for(clamp_sum(la, oa)), dac_dat_a);
    check_code("clamp low", code_for(clamp_sum(lb, ob)), dac_dat_b);
  end
  finish_test();
endtask

task automatic digital_loop();
  logic [`RP_DATA_W-1:0] rd;
  logic                  err;
  int                    la, oa, lb, ob;
  start_test("digital_loop");
  bus_write(REG_HK, 'h004, 32'd1, err);
  check_err("loop on err", 1'b0, err);
  bus_read(REG_HK, 'h004, rd, err);
  check_data("loop readback", 32'd1, rd);
  for (int i = 0; i < 3; i++)
  begin
    la = rand_signed(`RP_SMP_W);         // May saturate
    oa = rand_signed(`RP_SMP_W);
    lb = rand_signed(`RP_SMP_W);
    ob = rand_signed(`RP_SMP_W);
    write_dac(la, oa, lb, ob);
    adc_dat_a = rand_bits(`RP_ADC_RAW_W);  // Ignored while looped
    adc_dat_b = rand_bits(`RP_ADC_RAW_W);
    repeat (2) @(negedge adc_clk);
    bus_read(REG_ADC, 'h000, rd, err);
    check_data("looped a", clamp_sum(la, oa), rd);
    bus_read(REG_ADC, 'h004, rd, err);
    check_data("looped b", clamp_sum(lb, ob), rd);
  end
  bus_write(REG_HK, 'h004, 32'd0, err);
  repeat (2) @(negedge adc_clk);
  bus_read(REG_ADC, 'h000, rd, err);
  check_data("unlooped a", adc_word(adc_dat_a), rd);
  bus_read(REG_ADC, 'h004, rd, err);
  check_data("unlooped b", adc_word(adc_dat_b), rd);
  finish_test();
endtask

task automatic edge_count();
  logic [`RP_DATA_W-1:0] rd;
  logic                  err;
  int                    n_pulse [`RP_CNT_N];
  int                    clr;
  start_test("edge_count");
  for (int ch = 0; ch < `RP_CNT_N; ch++)
  begin
    n_pulse[ch] = int'(rand_bits(3)) + 1;
    for (int p = 0; p < n_pulse[ch]; p++)
    begin
      cnt_in[ch] = 1'b1;                 // Two cycles high, two low
      repeat (2) @(negedge adc_clk);
      cnt_in[ch] = 1'b0;
      repeat (2) @(negedge adc_clk);
    end
  end
  repeat (4) @(negedge adc_clk);         // Synchroniser and edge flop
  for (int ch = 0; ch < `RP_CNT_N; ch++)
  begin
    bus_read(REG_CNT, 4 * ch, rd, err);
    check_data("count", n_pulse[ch], rd);
  end
  clr = int'(rand_bits(2));
  bus_write(REG_CNT, 4 * clr, '0, err);
  check_err("clear err", 1'b0, err);
  for (int ch = 0; ch < `RP_CNT_N; ch++)
  begin
    bus_read(REG_CNT, 4 * ch, rd, err);
    check_data("after clear", (ch == clr) ? 0 : n_pulse[ch], rd);
  end
  finish_test();
endtask

//////////////////////////////////////////////////////////////////////
// Main sequence
//////////////////////////////////////////////////////////////////////

initial
begin
  host_req  = '0;
  adc_dat_a = '0;
  adc_dat_b = '0;
  cnt_in    = '0;
  lfsr_q    = 32'd98378;
  cycles    = 0;
  err_cnt   = 0;
  check_cnt = 0;
  test_cnt  = 0;
  wait (rst_n === 1'b1);
  @(negedge adc_clk);
  hk_and_errors();
  adc_conversion();
  dac_sum();
  dac_saturation();
  digital_loop();
  edge_count();
  $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
  if (err_cnt == 0)
    $display("Simulation passed");
  else
    $display("Simulation failed");
  $finish;
end

endmodule

// File: rp_analog_top.f
+incdir+include
src/rp_pkg.sv
src/rp_sys_decoder.sv
src/rp_hk_regs.sv
src/rp_adc_in.sv
src/rp_dac_out.sv
src/rp_edge_counter.sv
src/rp_analog_top.sv
test/rp_clk_gen.sv
test/rp_analog_sva.sv
test/rp_analog_tb.sv

// File: Bender.yml
package:
  name: rp_analog_top

sources:
  # Design
  - include_dirs:
      - include
    files:
      - src/rp_pkg.sv
      - src/rp_sys_decoder.sv
      - src/rp_hk_regs.sv
      - src/rp_adc_in.sv
      - src/rp_dac_out.sv
      - src/rp_edge_counter.sv
      - src/rp_analog_top.sv

  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - test/rp_clk_gen.sv
      - test/rp_analog_sva.sv
      - test/rp_analog_tb.sv
